//--- hw/st_glue_pkg.sv
//##########################################################
// shared types for the 68000 bus glue
// enums are sized to match the port widths in the design
// ipl codes are active low as the 68000 samples them
// ipl[0] stays high, so only levels 2, 4 and 6 exist
//##########################################################

package st_glue_pkg;

	// address classes seen by the decoder
	typedef enum logic [2:0] {
		REGION_NONE,
		REGION_RAM,
		REGION_ROM,
		REGION_IO,
		REGION_IACK
	} region_e;

	// implemented peripherals, index into the one-hot select
	typedef enum logic [3:0] {
		DEV_MMU,
		DEV_VIDEO,
		DEV_DMA,
		DEV_PSG,
		DEV_BLITTER,
		DEV_SND,
		DEV_JOY,
		DEV_MFP,
		DEV_ACIA
	} io_dev_e;

	localparam int NUM_IO_DEV = 9;

	// configured st ram size
	typedef enum logic [2:0] {
		MEM_512K,
		MEM_1M,
		MEM_2M,
		MEM_4M,
		MEM_8M,
		MEM_14M
	} mem_size_e;

	// cpu ipl pins, inverted level
	typedef enum logic [2:0] {
		IPL_MFP  = 3'd1,
		IPL_VBI  = 3'd3,
		IPL_HBI  = 3'd5,
		IPL_NONE = 3'd7
	} ipl_e;

	// autovector numbers handed out on iack
	localparam logic [7:0] VEC_VBI = 8'h1c;
	localparam logic [7:0] VEC_HBI = 8'h1a;

	// blank interrupt latch indices
	localparam int IRQ_HBI = 0;
	localparam int IRQ_VBI = 1;
	localparam int NUM_BLANK_IRQ = 2;

endpackage

//--- hw/st_addr_decode.sv
//##########################################################
// cpu_addr is a word address, bit n equals byte address bit n
// ram above 4 MB needs MEM_8M or MEM_14M, 14 MB at most
// no ide, scsi, fpu or rtc windows, those end in bus error
//##########################################################

`timescale 1ns/100ps

module st_addr_decode import st_glue_pkg::*; (
	input  logic [23:1]              cpu_addr,
	input  logic                     rw,
	input  mem_size_e                mem_size,
	input  logic                     ste,
	input  logic                     blitter_en,
	input  logic                     addr_strobe,
	output logic [NUM_IO_DEV-1:0]    dev_sel,
	output logic                     mem_sel,
	output logic                     ack_src,
	output logic [NUM_BLANK_IRQ-1:0] irq_ack,
	output logic [7:0]               auto_vector
);

	region_e               region;
	logic                  ram_hit;
	logic                  rom_hit;
	logic                  mem_hit;
	logic                  iack_cycle;
	logic                  mfp_iack;
	logic                  auto_iack;
	logic [2:0]            iack_level;
	logic [15:0]           io_off;
	logic [NUM_IO_DEV-1:0] dev_hit;

	// first 4 MB always ram
	always_comb begin
		ram_hit = (cpu_addr[23:22] == 2'b00);
		// 8 MB
		if (mem_size == MEM_8M || mem_size == MEM_14M)
			ram_hit = ram_hit || (cpu_addr[23:22] == 2'b01);
		// 12 MB and 14 MB
		if (mem_size == MEM_14M)
			ram_hit = ram_hit || (cpu_addr[23:22] == 2'b10) || (cpu_addr[23:21] == 3'b110);
	end

	// tos 256k at $e00000, tos 192k at $fc0000, cartridge at $fa0000
	assign rom_hit = (cpu_addr[23:18] == 6'b111000) ||
		(cpu_addr[23:17] == 7'b1111110) || (cpu_addr[23:16] == 8'hfe) ||
		(cpu_addr[23:17] == 7'b1111101);

	// iack window sits inside the io page, so it wins
	always_comb begin
		if (cpu_addr[23:4] == 20'hfffff)
			region = REGION_IACK;
		else if (cpu_addr[23:16] == 8'hff)
			region = REGION_IO;
		else if (ram_hit)
			region = REGION_RAM;
		else if (rom_hit)
			region = REGION_ROM;
		else
			region = REGION_NONE;
	end

	// rom only answers reads
	assign mem_hit = (region == REGION_RAM) || (region == REGION_ROM && rw);
	assign mem_sel = addr_strobe && mem_hit;

	// device windows within the $ff page
	assign io_off = {cpu_addr[15:1], 1'b0};
	always_comb begin
		dev_hit = '0;
		if (region == REGION_IO) begin
			dev_hit[DEV_MMU]     = (io_off == 16'h8000);
			dev_hit[DEV_VIDEO]   = ({io_off[15:7], 7'd0} == 16'h8200);
			dev_hit[DEV_DMA]     = ({io_off[15:4], 4'd0} == 16'h8600);
			dev_hit[DEV_PSG]     = ({io_off[15:8], 8'd0} == 16'h8800);
			// an ste always has a blitter
			dev_hit[DEV_BLITTER] = (blitter_en || ste) && ({io_off[15:8], 8'd0} == 16'h8a00);
			// ste only
			dev_hit[DEV_SND]     = ste && ({io_off[15:6], 6'd0} == 16'h8900);
			dev_hit[DEV_JOY]     = ste && ({io_off[15:6], 6'd0} == 16'h9200);
			dev_hit[DEV_MFP]     = ({io_off[15:6], 6'd0} == 16'hfa00);
			dev_hit[DEV_ACIA]    = ({io_off[15:8], 8'd0} == 16'hfc00);
		end
	end

	assign dev_sel = {NUM_IO_DEV{addr_strobe}} & dev_hit;

	// level 6 goes to the mfp, 4 and 2 are autovectored here
	assign iack_level = cpu_addr[3:1];
	assign iack_cycle = (region == REGION_IACK);
	assign mfp_iack   = iack_cycle && (iack_level == 3'd6);
	assign auto_iack  = iack_cycle && (iack_level == 3'd4 || iack_level == 3'd2);

	assign irq_ack[IRQ_VBI] = addr_strobe && iack_cycle && (iack_level == 3'd4);
	assign irq_ack[IRQ_HBI] = addr_strobe && iack_cycle && (iack_level == 3'd2);

	assign auto_vector = irq_ack[IRQ_VBI] ? VEC_VBI :
		(irq_ack[IRQ_HBI] ? VEC_HBI : 8'h00);

	// anything that may answer with dtack
	assign ack_src = mem_hit || (|dev_hit) || mfp_iack || auto_iack;

	// overlapping windows would drive two peripherals at once
	always_comb begin
		a_dev_sel_onehot: assert final ($onehot0(dev_sel))
			else $error("dev_sel not one-hot: %b", dev_sel);
	end

endmodule

//--- hw/st_bus_timeout.sv
//##########################################################
// every clk_8 cycle is a cpu cycle, no video slot sharing
// br only withholds dtack, nothing is tristated
// berr holds until clr_berr, DTACK_TIMEOUT must be 2..15
//##########################################################

`timescale 1ns/100ps

module st_bus_timeout #(
	parameter int unsigned DTACK_TIMEOUT = 7
) (
	input  logic clk_8,
	input  logic pll_locked,
	input  logic as_n,
	input  logic br,
	input  logic ack_src,
	input  logic clr_berr,
	output logic addr_strobe,
	output logic dtack_n,
	output logic berr
);

	localparam logic [3:0] CNT_MAX = 4'(DTACK_TIMEOUT);

	logic [3:0] nodtack_cnt;

	// strobe registered, dropped while another master holds the bus
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			addr_strobe <= 1'b0;
		end else begin
			addr_strobe <= !as_n && !br;
		end
	end

	assign dtack_n = !(addr_strobe && ack_src && !br);

	// saturated counter means bus error
	assign berr = (nodtack_cnt == CNT_MAX);

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			nodtack_cnt <= 4'd0;
		end else if (!berr) begin
			// any answer or a released strobe restarts the count
			if (!dtack_n || br || as_n)
				nodtack_cnt <= 4'd0;
			else if (addr_strobe)
				nodtack_cnt <= nodtack_cnt + 4'd1;
		end else if (clr_berr) begin
			// cpu has taken the bus error exception
			nodtack_cnt <= 4'd0;
		end
	end

	// a decoded cycle must never also run into the timeout
	a_no_dtack_in_berr: assert property (
		@(posedge clk_8) disable iff (!pll_locked)
		!(berr && !dtack_n)
	) else $error("berr and dtack seen together");

endmodule

//--- hw/st_irq_edge.sv
//##########################################################
// blank input is sampled on both clk_8 edges
// pending sets 1 to 3 cycles after a rising blank edge
// an ack in the same cycle as a new edge wins
//##########################################################

`timescale 1ns/100ps

module st_irq_edge (
	input  logic clk_8,
	input  logic pll_locked,
	input  logic blank,
	input  logic ack,
	output logic pending
);

	logic blank_neg;
	logic blank_pos;
	logic edge_pulse;

	// first sample on the falling edge
	always_ff @(negedge clk_8 or negedge pll_locked) begin
		if (!pll_locked)
			blank_neg <= 1'b0;
		else
			blank_neg <= blank;
	end

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			blank_pos  <= 1'b0;
			edge_pulse <= 1'b0;
			pending    <= 1'b0;
		end else begin
			// delayed copy, then a single cycle event
			blank_pos  <= blank_neg;
			edge_pulse <= blank_neg && !blank_pos;
			if (ack)
				pending <= 1'b0;
			else if (edge_pulse)
				pending <= 1'b1;
		end
	end

endmodule

//--- hw/st_ipl_encoder.sv
//##########################################################
// ipl is registered, one cycle behind its sources
// fixed priority mfp, then vbi, then hbi
//##########################################################

`timescale 1ns/100ps

module st_ipl_encoder import st_glue_pkg::*; (
	input  logic                     clk_8,
	input  logic                     pll_locked,
	input  logic [NUM_BLANK_IRQ-1:0] pending,
	input  logic                     mfp_irq,
	output ipl_e                     ipl
);

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			ipl <= IPL_NONE;
		end else begin
			// mfp at level 6
			if (mfp_irq)
				ipl <= IPL_MFP;
			// vbi at level 4
			else if (pending[IRQ_VBI])
				ipl <= IPL_VBI;
			// hbi at level 2
			else if (pending[IRQ_HBI])
				ipl <= IPL_HBI;
			else
				ipl <= IPL_NONE;
		end
	end

	// only even levels reach the cpu
	a_ipl_legal: assert property (
		@(posedge clk_8) disable iff (!pll_locked)
		ipl inside {IPL_NONE, IPL_HBI, IPL_VBI, IPL_MFP}
	) else $error("illegal ipl code %b", ipl);

endmodule

//--- hw/st_glue_top.sv
//##########################################################
// 68000 bus glue, asynchronous as_n/dtack_n cycle on clk_8
// cpu inputs must be stable while as_n is low
// st_vs and st_hs may be asynchronous to clk_8
//##########################################################

`timescale 1ns/100ps

module st_glue_top import st_glue_pkg::*; #(
	parameter int unsigned DTACK_TIMEOUT = 7
) (
	input  logic                  clk_8,
	input  logic                  pll_locked,
	input  logic [23:1]           cpu_addr,
	input  logic                  as_n,
	input  logic                  rw,
	input  logic                  br,
	input  logic                  clr_berr,
	input  mem_size_e             mem_size,
	input  logic                  ste,
	input  logic                  blitter_en,
	input  logic                  st_vs,
	input  logic                  st_hs,
	input  logic                  mfp_irq,
	output logic                  dtack_n,
	output logic                  berr,
	output logic [NUM_IO_DEV-1:0] dev_sel,
	output logic                  mem_sel,
	output ipl_e                  ipl,
	output logic [7:0]            auto_vector
);

	logic                     addr_strobe;
	logic                     ack_src;
	logic [NUM_BLANK_IRQ-1:0] irq_ack;
	logic [NUM_BLANK_IRQ-1:0] blank_src;
	logic [NUM_BLANK_IRQ-1:0] pending;

	// address, device and iack decode
	st_addr_decode st_addr_decode_inst (
		.cpu_addr    (cpu_addr),
		.rw          (rw),
		.mem_size    (mem_size),
		.ste         (ste),
		.blitter_en  (blitter_en),
		.addr_strobe (addr_strobe),
		.dev_sel     (dev_sel),
		.mem_sel     (mem_sel),
		.ack_src     (ack_src),
		.irq_ack     (irq_ack),
		.auto_vector (auto_vector)
	);

	// strobe, dtack and bus error
	st_bus_timeout #(
		.DTACK_TIMEOUT (DTACK_TIMEOUT)
	) st_bus_timeout_inst (
		.clk_8       (clk_8),
		.pll_locked  (pll_locked),
		.as_n        (as_n),
		.br          (br),
		.ack_src     (ack_src),
		.clr_berr    (clr_berr),
		.addr_strobe (addr_strobe),
		.dtack_n     (dtack_n),
		.berr        (berr)
	);

	// blank interrupt sources by latch index
	assign blank_src[IRQ_HBI] = st_hs;
	assign blank_src[IRQ_VBI] = st_vs;

	for (genvar i = 0; i < NUM_BLANK_IRQ; i++) begin : g_blank_irq
		st_irq_edge st_irq_edge_inst (
			.clk_8      (clk_8),
			.pll_locked (pll_locked),
			.blank      (blank_src[i]),
			.ack        (irq_ack[i]),
			.pending    (pending[i])
		);
	end

	st_ipl_encoder st_ipl_encoder_inst (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.pending    (pending),
		.mfp_irq    (mfp_irq),
		.ipl        (ipl)
	);

endmodule

//--- testbench/tb_st_glue.sv
//##########################################################
// drives st_glue_top from testbench/st_glue_tests.txt
// inputs change on the falling clk_8 edge, outputs are read there too
// stops on the first error, run length scales with the test count
//##########################################################

`timescale 1ns/100ps

module tb_st_glue import st_glue_pkg::*; ();

	localparam int unsigned DTACK_TIMEOUT = 7;

	logic                  clk_8 = 1'b0;
	logic                  pll_locked;
	logic [23:1]           cpu_addr;
	logic                  as_n;
	logic                  rw;
	logic                  br;
	logic                  clr_berr;
	mem_size_e             mem_size;
	logic                  ste;
	logic                  blitter_en;
	logic                  st_vs;
	logic                  st_hs;
	logic                  mfp_irq;
	logic                  dtack_n;
	logic                  berr;
	logic [NUM_IO_DEV-1:0] dev_sel;
	logic                  mem_sel;
	ipl_e                  ipl;
	logic [7:0]            auto_vector;

	int unsigned cycle_cnt = 0;
	int unsigned cycle_limit = 0;

	st_glue_top #(
		.DTACK_TIMEOUT (DTACK_TIMEOUT)
	) st_glue_top_inst (
		.clk_8       (clk_8),
		.pll_locked  (pll_locked),
		.cpu_addr    (cpu_addr),
		.as_n        (as_n),
		.rw          (rw),
		.br          (br),
		.clr_berr    (clr_berr),
		.mem_size    (mem_size),
		.ste         (ste),
		.blitter_en  (blitter_en),
		.st_vs       (st_vs),
		.st_hs       (st_hs),
		.mfp_irq     (mfp_irq),
		.dtack_n     (dtack_n),
		.berr        (berr),
		.dev_sel     (dev_sel),
		.mem_sel     (mem_sel),
		.ipl         (ipl),
		.auto_vector (auto_vector)
	);

	// 8 MHz nominal, 10 ns here
	always #5 clk_8 = ~clk_8;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	// limit is set once the test file is read
	always @(posedge clk_8) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt > cycle_limit)
			abort_run($sformatf("Timeout: run did not finish within %0d cycles", cycle_limit));
	end

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act));
	endtask

	task automatic check_ipl(input ipl_e exp);
		if (ipl !== exp)
			abort_run($sformatf("Mismatch at %0t: ipl expected %0d, got %0d", $time, exp, ipl));
	endtask

	// expected index turned into a one-hot select
	task automatic check_dev(input logic any_dev, input io_dev_e exp);
		logic [NUM_IO_DEV-1:0] want;
		want = '0;
		if (any_dev)
			want[exp] = 1'b1;
		if (dev_sel !== want)
			abort_run($sformatf("Mismatch at %0t: dev_sel expected %b, got %b",
				$time, want, dev_sel));
	endtask

	task automatic check_vector(input logic [7:0] exp);
		if (auto_vector !== exp)
			abort_run($sformatf("Mismatch at %0t: auto_vector expected %h, got %h",
				$time, exp, auto_vector));
	endtask

	// poll for the expected level, then compare
	task automatic wait_ipl(input ipl_e exp, input int limit);
		int n;
		n = 0;
		do begin
			@(negedge clk_8);
			n++;
		end while (ipl !== exp && n < limit);
		check_ipl(exp);
	endtask

	// strobe low until dtack_n or berr, as_n left low
	task automatic run_bus_cycle(input logic expect_ack, input logic any_dev,
		input io_dev_e dev, input logic exp_mem, input logic [7:0] exp_vec);
		int n;
		int limit;
		limit = expect_ack ? 3 : DTACK_TIMEOUT + 3;
		n = 0;
		as_n <= 1'b0;
		do begin
			@(negedge clk_8);
			n++;
		end while (dtack_n && !berr && n < limit);
		if (dtack_n && !berr)
			abort_run($sformatf("Bus cycle at %h got neither dtack_n nor berr within %0d cycles",
				{cpu_addr, 1'b0}, limit));
		// first response seen decides the cycle
		check_bit("dtack_n", !expect_ack, dtack_n);
		check_bit("berr", !expect_ack, berr);
		check_dev(any_dev, dev);
		check_bit("mem_sel", exp_mem, mem_sel);
		if (expect_ack)
			check_vector(exp_vec);
	endtask

	// cycle parked behind br for 20 cycles
	task automatic run_held_cycle(input logic any_dev, input io_dev_e dev,
		input logic exp_mem, input logic [7:0] exp_vec);
		br   <= 1'b1;
		as_n <= 1'b0;
		repeat (20) begin
			@(negedge clk_8);
			check_bit("dtack_n", 1'b1, dtack_n);
			check_bit("berr", 1'b0, berr);
		end
		br <= 1'b0;
		run_bus_cycle(1'b1, any_dev, dev, exp_mem, exp_vec);
	endtask

	task automatic pulse_blank(input logic vertical);
		if (vertical)
			st_vs <= 1'b1;
		else
			st_hs <= 1'b1;
		repeat (2) @(negedge clk_8);
		st_vs <= 1'b0;
		st_hs <= 1'b0;
	endtask

	// berr must hold until clr_berr, then drop within 2 cycles
	task automatic clear_bus_error();
		int n;
		check_bit("berr", 1'b1, berr);
		repeat (3) begin
			@(negedge clk_8);
			check_bit("berr", 1'b1, berr);
		end
		clr_berr <= 1'b1;
		n = 0;
		do begin
			@(negedge clk_8);
			n++;
		end while (berr && n < 2);
		clr_berr <= 1'b0;
		check_bit("berr", 1'b0, berr);
	endtask

	initial begin
		string       lines[$];
		string       line;
		string       op_s;
		string       resp_s;
		int          fd;
		int          cnt;
		int          rw_i;
		int          msz_i;
		int          ste_i;
		int          blt_i;
		int          mem_i;
		int          ipl_i;
		logic [23:0] addr;
		logic [3:0]  dev_x;
		logic [7:0]  vec_x;

		pll_locked = 1'b0;
		cpu_addr   = '0;
		as_n       = 1'b1;
		rw         = 1'b1;
		br         = 1'b0;
		clr_berr   = 1'b0;
		mem_size   = MEM_4M;
		ste        = 1'b0;
		blitter_en = 1'b0;
		st_vs      = 1'b0;
		st_hs      = 1'b0;
		mfp_irq    = 1'b0;

		fd = $fopen("testbench/st_glue_tests.txt", "r");
		if (fd == 0)
			abort_run("Cannot open testbench/st_glue_tests.txt");
		// keep only lines with an operation
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#")
				lines.push_back(line);
		end
		$fclose(fd);
		cycle_limit = 40 * lines.size() + 16 + 4;

		repeat (16) @(posedge clk_8);
		@(negedge clk_8);
		pll_locked <= 1'b1;
		repeat (2) @(negedge clk_8);

		foreach (lines[i]) begin
			cnt = $sscanf(lines[i], "%s %h %d %d %d %d %s %h %d %d %h", op_s, addr, rw_i,
				msz_i, ste_i, blt_i, resp_s, dev_x, mem_i, ipl_i, vec_x);
			if (cnt != 11)
				abort_run($sformatf("Test line %0d could not be parsed", i + 1));
			cpu_addr   <= addr[23:1];
			rw         <= rw_i[0];
			mem_size   <= mem_size_e'(msz_i);
			ste        <= ste_i[0];
			blitter_en <= blt_i[0];
			case (op_s)
				"b": run_bus_cycle(resp_s == "a", dev_x != 4'hf, io_dev_e'(dev_x),
					mem_i[0], vec_x);
				"r": run_held_cycle(dev_x != 4'hf, io_dev_e'(dev_x), mem_i[0], vec_x);
				"v": pulse_blank(1'b1);
				"h": pulse_blank(1'b0);
				"m": mfp_irq <= rw_i[0];
				"c": clear_bus_error();
				default: abort_run($sformatf("Unknown operation %s on test line %0d", op_s, i + 1));
			endcase
			// cpu ends the cycle, ipl settles
			as_n <= 1'b1;
			wait_ipl(ipl_e'(ipl_i[2:0]), 4);
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- testbench/st_glue_tests.txt
# op byte_addr rw mem_size ste blitter_en resp(a ack/e berr/-) dev(f none) mem_sel ipl vector
# op b bus cycle, r cycle held by br, v vsync, h hsync, m mfp level in rw, c clr_berr
b ff8000 1 3 0 0 a 0 0 7 00
b ff8200 1 3 0 0 a 1 0 7 00
b ff8604 0 3 0 0 a 2 0 7 00
b ff8800 1 3 0 0 a 3 0 7 00
b ff8a00 1 3 0 1 a 4 0 7 00
b ff8900 1 3 1 0 a 5 0 7 00
b ff9200 1 3 1 0 a 6 0 7 00
b fffa00 1 3 0 0 a 7 0 7 00
b fffc02 1 3 0 0 a 8 0 7 00
b ff8900 1 3 0 0 e f 0 7 00
c 000000 1 3 0 0 - f 0 7 00
b ff9200 1 3 0 0 e f 0 7 00
c 000000 1 3 0 0 - f 0 7 00
b 500000 1 3 0 0 e f 0 7 00
c 000000 1 3 0 0 - f 0 7 00
b 500000 1 4 0 0 a f 1 7 00
b d00000 0 5 0 0 a f 1 7 00
b fc0010 1 3 0 0 a f 1 7 00
b fc0010 0 3 0 0 e f 0 7 00
c 000000 1 3 0 0 - f 0 7 00
b ff8100 1 3 0 0 e f 0 7 00
c 000000 1 3 0 0 - f 0 7 00
r 001000 0 3 0 0 a f 1 7 00
v 000000 1 3 0 0 - f 0 3 00
b fffff8 1 3 0 0 a f 0 7 1c
h 000000 1 3 0 0 - f 0 5 00
b fffff4 1 3 0 0 a f 0 7 1a
v 000000 1 3 0 0 - f 0 3 00
m 000000 1 3 0 0 - f 0 1 00
b fffffc 1 3 0 0 a f 0 1 00
m 000000 0 3 0 0 - f 0 3 00
b fffff8 1 3 0 0 a f 0 7 1c

//--- build.f
hw/st_glue_pkg.sv
hw/st_addr_decode.sv
hw/st_bus_timeout.sv
hw/st_irq_edge.sv
hw/st_ipl_encoder.sv
hw/st_glue_top.sv
testbench/tb_st_glue.sv

//--- Bender.yml
package:
  name: st_glue

sources:
  - hw/st_glue_pkg.sv
  - hw/st_addr_decode.sv
  - hw/st_bus_timeout.sv
  - hw/st_irq_edge.sv
  - hw/st_ipl_encoder.sv
  - hw/st_glue_top.sv
  - target: test
    files:
      - testbench/tb_st_glue.sv
